/* flist.f */
verilog/link_pkg.sv
verilog/display_pkg.sv
verilog/key_debounce.sv
verilog/spi_cmd_slave.sv
verilog/seg7_display.sv
verilog/board_ctrl.sv
tb/tb_board_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the board_ctrl testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --top-module tb_board_ctrl \
    -Mdir "$build_dir" -o sim_board_ctrl -f flist.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$build_dir/sim_board_ctrl" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$log"; then
    exit 1
fi
exit 0

/* tb/tb_board_ctrl.sv */
module tb_board_ctrl
        import link_pkg::*, display_pkg::*;
;
        timeunit 1ns;
        timeprecision 100ps;

        typedef enum logic [2:0] {op_frame, op_short, op_press, op_glitch, op_blank} op_t;

        typedef struct packed {
                op_t         op;
                cmd_t        data;                      // byte on mosi
                bit_cnt_t    nbits;                     // sclk rises in the frame
                logic [23:0] hist;                      // expected history, oldest byte on top
        } row_t;

        localparam int num_rows = 11;

        // gfedcba, active low
        localparam seg_t seg_ref [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02,
                7'h78, 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

        logic clock_50;
        logic rst_n;
        logic spi_sclk;
        logic spi_csel;
        logic spi_mosi;
        logic spi_miso;
        key_t key;
        seg_t hex [num_digits];
        row_t rows [num_rows];
        cmd_t last_good;                                // byte that miso must echo
        cmd_t miso_byte;
        int   errors;
        int   n_pass;
        int   n_fail;
        int   e0;

        board_ctrl #(.debounce_cycles(16), .cnt_width(16)) dut0 (
                .clock_50(clock_50), .rst_n(rst_n), .key(key),
                .spi_sclk(spi_sclk), .spi_csel(spi_csel), .spi_mosi(spi_mosi),
                .spi_miso(spi_miso), .hex0(hex[0]), .hex1(hex[1]), .hex2(hex[2]),
                .hex3(hex[3]), .hex4(hex[4]), .hex5(hex[5]));

        initial begin
                clock_50 = 1'b0;
                forever #20 clock_50 = ~clock_50;      // 25 MHz in sim
        end

        // ========================================
        // compare tasks
        // ========================================
        task automatic check_seg(input string name, input seg_t exp, input seg_t act);
                if (exp !== act) begin
                        $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
                        errors++;
                end
        endtask

        task automatic check_byte(input string name, input cmd_t exp, input cmd_t act);
                if (exp !== act) begin
                        $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
                        errors++;
                end
        endtask

        task automatic check_key(input string name, input key_t exp, input key_t act);
                if (exp !== act) begin
                        $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
                        errors++;
                end
        endtask

        function automatic seg_t exp_seg(input logic [23:0] hist, input logic blank, input int i);
                return blank ? seg_blank : seg_ref[hist[i*4 +: 4]];     // hex0 = low nibble
        endfunction

        task automatic check_display(input logic [23:0] hist, input logic blank);
                for (int i = 0; i < num_digits; i++)
                        check_seg($sformatf("hex%0d", i), exp_seg(hist, blank, i), hex[i]);
        endtask

        // ========================================
        // waits and drivers
        // ========================================
        task automatic ticks(input int n);
                repeat (n) @(posedge clock_50);
                #2;                                     // drive just after the edge
        endtask

        task automatic wait_display(input logic [23:0] hist, input logic blank, input int limit);
                int  n;
                logic match;
                n = 0;
                match = 1'b0;
                while (!match && n < limit) begin
                        @(negedge clock_50);            // outputs settled
                        match = 1'b1;
                        for (int i = 0; i < num_digits; i++)
                                if (hex[i] !== exp_seg(hist, blank, i))
                                        match = 1'b0;
                        n++;
                end
                if (!match) begin
                        $display("timeout at %0t: display never showed %h within %0d clocks",
                                $time, hist, limit);
                        errors++;
                end
                check_display(hist, blank);
        endtask

        task automatic wait_key(input key_t exp, input int limit);
                int n;
                n = 0;
                while (dut0.u_seg7_display.key_db !== exp && n < limit) begin
                        @(negedge clock_50);
                        n++;
                end
                if (dut0.u_seg7_display.key_db !== exp)
                        $display("timeout at %0t: debounced keys never reached %b", $time, exp);
                check_key("key_db", exp, dut0.u_seg7_display.key_db);
        endtask

        // mode 0 master, 16 clocks per bit, miso read just before each rise
        task automatic send_frame(input cmd_t data, input int nbits, output cmd_t got);
                got = '0;
                spi_csel = 1'b0;
                for (int i = 0; i < nbits; i++) begin
                        spi_mosi = (i < 8) ? data[7-i] : 1'b0;  // overrun bits are zero
                        ticks(8);
                        if (i < 8)
                                got[7-i] = spi_miso;
                        spi_sclk = 1'b1;
                        ticks(8);
                        spi_sclk = 1'b0;
                end
                ticks(8);
                spi_csel = 1'b1;
                spi_mosi = 1'b0;
        endtask

        task automatic report(input int t, input string what);
                if (errors == e0) begin
                        n_pass++;
                        $display("test %0d %s: ok", t, what);
                end else begin
                        n_fail++;
                        $display("test %0d %s: %0d errors", t, what, errors - e0);
                end
        endtask

        // ========================================
        // stimulus table and main sequence
        // ========================================
        initial begin
                void'($urandom(32'hc7b8));
                errors = 0;
                n_pass = 0;
                n_fail = 0;
                last_good = '0;                         // nothing received yet
                rst_n = 1'b0;
                key = '1;                               // released
                spi_sclk = 1'b0;
                spi_csel = 1'b1;
                spi_mosi = 1'b0;
                rows[0]  = '{op_frame,  8'h3c, 4'd8, 24'h00003c};
                rows[1]  = '{op_frame,  8'ha5, 4'd8, 24'h003ca5};
                rows[2]  = '{op_frame,  8'h7e, 4'd8, 24'h3ca57e};
                rows[3]  = '{op_short,  8'h55, 4'd5, 24'h3ca57e};       // under length
                rows[4]  = '{op_short,  8'h99, 4'd9, 24'h3ca57e};       // overrun
                rows[5]  = '{op_frame,  8'h12, 4'd8, 24'ha57e12};
                rows[6]  = '{op_glitch, 8'h00, 4'd0, 24'ha57e12};
                rows[7]  = '{op_press,  8'h00, 4'd0, 24'h000000};
                rows[8]  = '{op_frame,  8'hc4, 4'd8, 24'h0000c4};
                rows[9]  = '{op_blank,  8'h6b, 4'd8, 24'h00c46b};
                rows[10] = '{op_frame,  8'hf0, 4'd8, 24'hc46bf0};
                ticks(10);
                rst_n = 1'b1;
                e0 = errors;
                wait_display(24'h0, 1'b0, 5);
                check_byte("spi_miso", 8'h00, cmd_t'(spi_miso));
                report(0, "reset");
                for (int r = 0; r < num_rows; r++) begin
                        e0 = errors;
                        ticks($urandom_range(20, 4));   // idle gap between tests
                        case (rows[r].op)
                        op_frame, op_short: begin
                                send_frame(rows[r].data, int'(rows[r].nbits), miso_byte);
                                if (rows[r].nbits >= cmd_bits)
                                        check_byte("spi_miso", last_good, miso_byte);
                                if (rows[r].nbits == cmd_bits)
                                        last_good = rows[r].data;
                                if (rows[r].op == op_frame) begin
                                        wait_display(rows[r].hist, 1'b0, 10);
                                end else begin
                                        ticks(10);
                                        check_display(rows[r].hist, 1'b0);
                                end
                        end
                        op_glitch: begin
                                key[0] = 1'b0;
                                ticks(8);               // half the debounce time
                                key[0] = 1'b1;
                                ticks(30);
                                check_display(rows[r].hist, 1'b0);
                                check_key("key_db", 2'b11, dut0.u_seg7_display.key_db);
                        end
                        op_press: begin
                                key[0] = 1'b0;
                                ticks(40);
                                check_key("key_db", 2'b10, dut0.u_seg7_display.key_db);
                                check_display(rows[r].hist, 1'b0);
                                key[0] = 1'b1;
                                wait_key(2'b11, 30);
                        end
                        default: begin
                                key[1] = 1'b0;
                                wait_display(rows[r].hist, 1'b1, 30);   // blank hides history
                                check_key("key_db", 2'b01, dut0.u_seg7_display.key_db);
                                ticks(1);
                                send_frame(rows[r].data, int'(rows[r].nbits), miso_byte);
                                check_byte("spi_miso", last_good, miso_byte);
                                last_good = rows[r].data;
                                ticks(10);
                                check_display(rows[r].hist, 1'b1);
                                key[1] = 1'b1;
                                wait_display(rows[r].hist, 1'b0, 30);
                                wait_key(2'b11, 10);
                        end
                        endcase
                        report(r + 1, rows[r].op.name());
                end
                $display("tests passed %0d, failed %0d", n_pass, n_fail);
                if (errors == 0) begin
                        $display("*** PASSED ***");
                end else begin
                        $display("*** FAILED ***");
                end
                $finish;
        end

endmodule : tb_board_ctrl

/* verilog/board_ctrl.sv */
module board_ctrl
        import link_pkg::*, display_pkg::*;
#(
        parameter int debounce_cycles = 50000,  // 1 ms at 50 MHz
        parameter int cnt_width       = 16
)(
        input  logic clock_50,
        input  logic rst_n,
        input  key_t key,                       // raw, active low
        input  logic spi_sclk,
        input  logic spi_csel,                  // active low
        input  logic spi_mosi,
        output logic spi_miso,
        output seg_t hex0,
        output seg_t hex1,
        output seg_t hex2,
        output seg_t hex3,
        output seg_t hex4,
        output seg_t hex5
);

        key_t key_db;                           // debounced keys
        cmd_t cmd_byte;
        logic cmd_valid;

        key_debounce #(
                .debounce_cycles (debounce_cycles),
                .cnt_width       (cnt_width)
        ) u_key_debounce (
                .clock_50 (clock_50),
                .rst_n    (rst_n),
                .key      (key),
                .key_db   (key_db)
        );

        spi_cmd_slave u_spi_cmd_slave (
                .clock_50  (clock_50),
                .rst_n     (rst_n),
                .spi_sclk  (spi_sclk),
                .spi_csel  (spi_csel),
                .spi_mosi  (spi_mosi),
                .spi_miso  (spi_miso),
                .cmd_byte  (cmd_byte),
                .cmd_valid (cmd_valid)
        );

        seg7_display u_seg7_display (
                .clock_50  (clock_50),
                .rst_n     (rst_n),
                .cmd_byte  (cmd_byte),
                .cmd_valid (cmd_valid),
                .key_db    (key_db),
                .hex0      (hex0),
                .hex1      (hex1),
                .hex2      (hex2),
                .hex3      (hex3),
                .hex4      (hex4),
                .hex5      (hex5)
        );

endmodule : board_ctrl

/* verilog/display_pkg.sv */
// ========================================
// seven segment display types
// ========================================
package display_pkg;

        typedef logic [6:0] seg_t;      // active low, g down to a
        typedef logic [3:0] nibble_t;   // one hex digit

        localparam int num_digits = 6;  // hex0 .. hex5

        localparam seg_t seg_blank = 7'h7f;     // every segment off

        // hex digit to segment pattern, gfedcba, 0 lights a segment
        localparam seg_t seg_table [16] = '{
                7'h40,  // 0
                7'h79,  // 1
                7'h24,  // 2
                7'h30,  // 3
                7'h19,  // 4
                7'h12,  // 5
                7'h02,  // 6
                7'h78,  // 7
                7'h00,  // 8
                7'h10,  // 9
                7'h08,  // a
                7'h03,  // b, lower case form
                7'h46,  // c
                7'h21,  // d, lower case form
                7'h06,  // e
                7'h0e   // f
        };

endpackage : display_pkg

/* verilog/key_debounce.sv */
module key_debounce
        import link_pkg::*;
#(
        parameter int debounce_cycles = 50000,  // stable clocks before a change is taken
        parameter int cnt_width       = 16      // must hold debounce_cycles - 1
)(
        input  logic clock_50,
        input  logic rst_n,
        input  key_t key,                       // raw pins, active low
        output key_t key_db                     // accepted level, active low
);

        localparam int num_keys = $bits(key_t);
        localparam logic [cnt_width-1:0] cnt_last = cnt_width'(debounce_cycles - 1);

        key_t key_s1;                           // first sync stage
        key_t key_s2;                           // second sync stage, safe to use
        logic [cnt_width-1:0] cnt [num_keys];   // clocks the new level has held

        // ========================================
        // input synchronizer
        // ========================================
        always_ff @(posedge clock_50 or negedge rst_n) begin
                if (!rst_n) begin
                        key_s1 <= '1;           // released
                        key_s2 <= '1;
                end else begin
                        key_s1 <= key;
                        key_s2 <= key_s1;
                end
        end

        // ========================================
        // per key stable counter
        // ========================================
        // counting only runs while the synced level differs from the
        // accepted one, so any bounce back restarts it from zero
        always_ff @(posedge clock_50 or negedge rst_n) begin
                if (!rst_n) begin
                        key_db <= '1;
                        for (int i = 0; i < num_keys; i++)
                                cnt[i] <= '0;
                end else begin
                        for (int i = 0; i < num_keys; i++) begin
                                if (key_s2[i] == key_db[i]) begin
                                        cnt[i] <= '0;                   // nothing pending
                                end else if (cnt[i] == cnt_last) begin
                                        key_db[i] <= key_s2[i];         // held long enough
                                        cnt[i]    <= '0;
                                end else begin
                                        cnt[i] <= cnt[i] + 1'b1;
                                end
                        end
                end
        end

endmodule : key_debounce

/* verilog/link_pkg.sv */
// ========================================
// key and spi link types
// ========================================
package link_pkg;

        // raw or debounced keys, active low
        typedef logic [1:0] key_t;

        // one spi command byte, msb first on the wire
        typedef logic [7:0] cmd_t;

        // bits seen in a frame, wide enough to catch an overrun
        typedef logic [3:0] bit_cnt_t;

        // receiver fsm
        typedef enum logic [1:0] {
                idle  = 2'd0,           // chip select high, waiting
                shift = 2'd1,           // frame open, sampling mosi
                done  = 2'd2            // frame closed, one cycle to judge it
        } spi_state_t;

        // a good frame has exactly this many sclk rises
        localparam bit_cnt_t cmd_bits = 4'd8;

endpackage : link_pkg

/* verilog/seg7_display.sv */
module seg7_display
        import link_pkg::*, display_pkg::*;
(
        input  logic clock_50,
        input  logic rst_n,
        input  cmd_t cmd_byte,
        input  logic cmd_valid,                 // single cycle, no back-pressure
        input  key_t key_db,                    // bit 0 clears, bit 1 blanks, active low
        output seg_t hex0,
        output seg_t hex1,
        output seg_t hex2,
        output seg_t hex3,
        output seg_t hex4,
        output seg_t hex5
);

        localparam int nib_bits  = $bits(nibble_t);
        localparam int hist_bits = num_digits * nib_bits;      // three bytes
        localparam int cmd_w     = $bits(cmd_t);

        logic [hist_bits-1:0] history;          // newest byte in the low end
        logic    blank_q;                       // key 1 held, registered
        nibble_t digit [num_digits];
        seg_t    seg   [num_digits];

        // ========================================
        // command history
        // ========================================
        always_ff @(posedge clock_50 or negedge rst_n) begin
                if (!rst_n) begin
                        history <= '0;          // shows 000000
                        blank_q <= 1'b0;
                end else begin
                        if (!key_db[0])
                                history <= '0;  // clear wins over a new byte
                        else if (cmd_valid)
                                history <= {history[hist_bits-cmd_w-1:0], cmd_byte};
                        blank_q <= ~key_db[1];  // history kept while blank
                end
        end

        // ========================================
        // hex decode
        // ========================================
        always_comb begin
                for (int i = 0; i < num_digits; i++) begin
                        digit[i] = history[i*nib_bits +: nib_bits];
                        seg[i]   = blank_q ? seg_blank : seg_table[digit[i]];
                end
        end

        assign hex0 = seg[0];                   // low nibble of newest byte
        assign hex1 = seg[1];
        assign hex2 = seg[2];
        assign hex3 = seg[3];
        assign hex4 = seg[4];
        assign hex5 = seg[5];                   // high nibble of oldest byte

        // history, blank flag and upstream byte must all be known once out of reset
        a_hex_known: assert property (@(posedge clock_50) disable iff (!rst_n)
                !$isunknown({hex5, hex4, hex3, hex2, hex1, hex0}));

endmodule : seg7_display

/* verilog/spi_cmd_slave.sv */
module spi_cmd_slave
        import link_pkg::*;
(
        input  logic clock_50,
        input  logic rst_n,
        input  logic spi_sclk,
        input  logic spi_csel,                  // active low frame
        input  logic spi_mosi,
        output logic spi_miso,
        output cmd_t cmd_byte,                  // last byte shifted in
        output logic cmd_valid                  // one clock per good frame
);

        logic [2:0] sclk_sync;                  // two sync flops + edge history
        logic [2:0] csel_sync;
        logic [1:0] mosi_sync;

        logic sclk_rise;
        logic sclk_fall;
        logic csel_rise;
        logic csel_fall;

        spi_state_t state;
        bit_cnt_t   bit_cnt;                    // sclk rises this frame
        cmd_t       rx_shift;                   // receive shifter
        cmd_t       last_byte;                  // last good byte, echoed next frame
        cmd_t       tx_shift;                   // transmit shifter

        // ========================================
        // pin synchronizers and edge detect
        // ========================================
        always_ff @(posedge clock_50 or negedge rst_n) begin
                if (!rst_n) begin
                        sclk_sync <= 3'b000;
                        csel_sync <= 3'b111;    // deselected
                        mosi_sync <= 2'b00;
                end else begin
                        sclk_sync <= {sclk_sync[1:0], spi_sclk};
                        csel_sync <= {csel_sync[1:0], spi_csel};
                        mosi_sync <= {mosi_sync[0], spi_mosi};
                end
        end

        assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
        assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
        assign csel_rise = csel_sync[1] & ~csel_sync[2];        // frame end
        assign csel_fall = ~csel_sync[1] & csel_sync[2];        // frame start

        // ========================================
        // receive fsm
        // ========================================
        always_ff @(posedge clock_50 or negedge rst_n) begin
                if (!rst_n) begin
                        state   <= idle;
                        bit_cnt <= '0;
                end else begin
                        case (state)
                        idle: begin
                                if (csel_fall) begin
                                        state   <= shift;
                                        bit_cnt <= '0;
                                end
                        end
                        shift: begin
                                if (csel_rise)
                                        state <= done;
                                else if (sclk_rise && bit_cnt != '1)
                                        bit_cnt <= bit_cnt + 1'b1;      // saturates at 15
                        end
                        done:    state <= idle;
                        default: state <= idle;
                        endcase
                end
        end

        always_ff @(posedge clock_50) begin
                if (state == shift && sclk_rise && !csel_rise)
                        rx_shift <= {rx_shift[6:0], mosi_sync[1]};      // msb first
        end

        // only an exact 8 bit frame counts, 3 clocks after csel rises at the pin
        assign cmd_valid = (state == done) && (bit_cnt == cmd_bits);
        assign cmd_byte  = rx_shift;

        // ========================================
        // miso echo
        // ========================================
        always_ff @(posedge clock_50 or negedge rst_n) begin
                if (!rst_n) begin
                        last_byte <= '0;
                        tx_shift  <= '0;
                end else begin
                        if (cmd_valid)
                                last_byte <= rx_shift;
                        if (state == idle && csel_fall)
                                tx_shift <= last_byte;                  // bit 7 out at once
                        else if (state == shift && sclk_fall)
                                tx_shift <= {tx_shift[6:0], 1'b0};      // next bit after fall
                end
        end

        assign spi_miso = tx_shift[7];

        a_valid_one_cycle: assert property (@(posedge clock_50) disable iff (!rst_n)
                cmd_valid |=> !cmd_valid);

        // one cycle of done is allowed after csel goes high, then idle
        a_idle_deselected: assert property (@(posedge clock_50) disable iff (!rst_n)
                csel_sync[1] && csel_sync[2] |=> state == idle);

endmodule : spi_cmd_slave
